/* alu/aluCore.sv */
`timescale 1ns/10ps

module aluCore import mipsPkg::*; (
	input aluOpT aluOp,
	// rs operand, also the variable shift amount
	input wordT a,
	// rt or immediate, the value being shifted
	input wordT b,
	input logic [4:0] shamt,
	output wordT result,
	output logic ovf
);

	////////////////////////////////////////////////////////////
	// Adder and subtractor
	////////////////////////////////////////////////////////////

	wordT sum;
	wordT diff;
	logic addOvf;
	logic subOvf;
	// Variable shift amount
	logic [4:0] varShamt;

	assign sum = a + b;
	assign diff = a - b;
	assign varShamt = a[4:0];

	// Same operand signs but result sign flipped
	assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
	// Opposite operand signs and result takes sign of b
	assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

	// Only the trapping forms report
	assign ovf = ((aluOp == functAdd) && addOvf) || ((aluOp == functSub) && subOvf);

	////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (aluOp)
			// Arithmetic
			functAdd, functAddu:
				result = sum;
			functSub, functSubu:
				result = diff;
			// Bitwise logic
			functAnd:
				result = a & b;
			functOr:
				result = a | b;
			functXor:
				result = a ^ b;
			functNor:
				result = ~(a | b);
			// Set on less than
			functSlt:
				result = {31'b0, ($signed(a) < $signed(b))};
			functSltu:
				result = {31'b0, (a < b)};
			// Fixed shifts
			functSll:
				result = b << shamt;
			functSrl:
				result = b >> shamt;
			functSra:
				result = $signed(b) >>> shamt;
			// Variable shifts, low 5 bits of rs
			functSllv:
				result = b << varShamt;
			functSrlv:
				result = b >> varShamt;
			functSrav:
				result = $signed(b) >>> varShamt;
			// Upper immediate
			aluLui:
				result = {b[15:0], 16'b0};
			default:
				result = '0;
		endcase
	end

endmodule

/* bench/clkGen.sv */
`timescale 1ns/10ps

module clkGen (
	output logic clk,
	output logic rstN
);

	// Reset length in clock cycles
	localparam int resetCycles = 16;

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		// Clean falling edge on reset
		rstN = 1'b1;
		#1;
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		// Release away from the active edge
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

/* bench/execCoreProps.sv */
`timescale 1ns/10ps

module execCoreProps import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbValid,
	input regAddrT wbAddr,
	input logic overflow,
	input logic illegal
);

	////////////////////////////////////////////////////////////
	// Writeback status
	////////////////////////////////////////////////////////////

	// One outcome per retiring instruction
	onlyOneOutcome: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({wbValid, overflow, illegal}))
		else $error("wbValid, overflow and illegal high in the same cycle");

	// r0 is never a committed target
	noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> (wbAddr != '0))
		else $error("writeback targets register 0");

	////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////

	flagsLowInReset: assert property (@(posedge clk)
		!rstN |-> !(wbValid || overflow || illegal))
		else $error("status flags high while reset is asserted");

endmodule

/* bench/tbExecCore.sv */
`timescale 1ns/10ps

module tbExecCore import mipsPkg::*; ();

	localparam int randSeed = 67368;
	// Instructions per test
	localparam int logicOps = 60;
	localparam int shiftOps = 48;
	localparam int compareOps = 16;
	localparam int ovfOps = 24;
	localparam int chainOps = 48;
	localparam int zeroOps = 16;
	localparam int illegalOps = 24;
	// Loads, reloads, debug sweeps and drains on top of the plain ops
	localparam int testCycles = 2 * numRegs + logicOps + 16 + shiftOps + 6 * compareOps
		+ 5 * ovfOps + chainOps + zeroOps + illegalOps + 3 * (numRegs + 3) + 6 * 2;
	localparam int cycleLimit = 16 + testCycles + 200;

	logic clk;
	logic rstN;
	wordT instr;
	logic instrValid;
	regAddrT dbgAddr;
	wordT dbgData;
	logic wbValid;
	regAddrT wbAddr;
	wordT wbData;
	logic overflow;
	logic illegal;

	// Architectural model
	wordT modelRegs [numRegs];
	// Predictions, index 0 issued last cycle and index 1 the one before
	logic predWb [2];
	regAddrT predAddr [2];
	wordT predData [2];
	logic predOvf [2];
	logic predIll [2];

	string testName;
	int checkCount;
	int errorCount;
	int testErrors;
	int testCount;
	int cycleCount = 0;

	clkGen clockGen (
		.clk(clk),
		.rstN(rstN)
	);

	execCore DUT (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.instrValid(instrValid),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.overflow(overflow),
		.illegal(illegal)
	);

	bind execCore execCoreProps props (
		.clk(clk),
		.rstN(rstN),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.overflow(overflow),
		.illegal(illegal)
	);

	// Run length guard
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Run stopped, tests did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic checkEq(input string what, input wordT expected, input wordT actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			testErrors++;
			$display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic wordT arithRight(input wordT value, input logic [4:0] amount);
		wordT fill;
		// Sign bits fill the vacated top
		fill = value[31] ? ~(32'hFFFF_FFFF >> amount) : 32'h0;
		return (value >> amount) | fill;
	endfunction

	function automatic logic functKnown(input logic [5:0] code);
		case (code)
			functAdd, functAddu, functSub, functSubu, functAnd, functOr, functXor,
			functNor, functSlt, functSltu, functSll, functSrl, functSra, functSllv,
			functSrlv, functSrav:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic modelExec(input wordT word, output logic wb, output regAddrT addr,
		output wordT data, output logic ovf, output logic ill);
		wordT a;
		wordT b;
		logic [4:0] sa;
		longint wide;
		logic wr;
		a = modelRegs[word[25:21]];
		b = modelRegs[word[20:16]];
		sa = word[10:6];
		addr = word[15:11];
		data = '0;
		wide = 0;
		ill = 1'b0;
		wr = 1'b1;
		if (word[31:26] == opRType)
		begin
			case (word[5:0])
				functAdd, functAddu:
				begin
					data = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
				end
				functSub, functSubu:
				begin
					data = a - b;
					wide = longint'($signed(a)) - longint'($signed(b));
				end
				functAnd: data = a & b;
				functOr: data = a | b;
				functXor: data = a ^ b;
				functNor: data = ~(a | b);
				functSlt: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				functSltu: data = (a < b) ? 32'd1 : 32'd0;
				functSll: data = b << sa;
				functSrl: data = b >> sa;
				functSra: data = arithRight(b, sa);
				// Amount from the low bits of rs only
				functSllv: data = b << a[4:0];
				functSrlv: data = b >> a[4:0];
				functSrav: data = arithRight(b, a[4:0]);
				default:
				begin
					ill = 1'b1;
					wr = 1'b0;
				end
			endcase
		end
		else
		begin
			// I-type writes rt
			addr = word[20:16];
			case (word[31:26])
				opAddiu: data = a + {{16{word[15]}}, word[15:0]};
				opOri: data = a | {16'h0, word[15:0]};
				opLui: data = {word[15:0], 16'h0};
				default:
				begin
					ill = 1'b1;
					wr = 1'b0;
				end
			endcase
		end
		// True sum out of 32-bit signed range
		ovf = !ill && (word[31:26] == opRType)
			&& (word[5:0] == functAdd || word[5:0] == functSub)
			&& (wide != longint'($signed(data)));
		wb = wr && !ovf && (addr != '0);
		if (wb)
			modelRegs[addr] = data;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// Check what retires at this falling edge, then drive the next slot
	task automatic tick(input logic valid, input wordT word);
		logic wb;
		regAddrT addr;
		wordT data;
		logic ovf;
		logic ill;
		@(negedge clk);
		checkEq("wbValid", wordT'(predWb[1]), wordT'(wbValid));
		checkEq("overflow", wordT'(predOvf[1]), wordT'(overflow));
		checkEq("illegal", wordT'(predIll[1]), wordT'(illegal));
		if (predWb[1])
		begin
			checkEq("wbAddr", wordT'(predAddr[1]), wordT'(wbAddr));
			checkEq("wbData", predData[1], wbData);
		end
		wb = 1'b0;
		addr = '0;
		data = '0;
		ovf = 1'b0;
		ill = 1'b0;
		if (valid)
			modelExec(word, wb, addr, data, ovf, ill);
		predWb[1] = predWb[0];
		predAddr[1] = predAddr[0];
		predData[1] = predData[0];
		predOvf[1] = predOvf[0];
		predIll[1] = predIll[0];
		predWb[0] = wb;
		predAddr[0] = addr;
		predData[0] = data;
		predOvf[0] = ovf;
		predIll[0] = ill;
		instrValid = valid;
		instr = word;
	endtask

	function automatic wordT rType(input logic [5:0] funct, input regAddrT rs,
		input regAddrT rt, input regAddrT rd, input logic [4:0] sa);
		return {opRType, rs, rt, rd, sa, funct};
	endfunction

	function automatic wordT iType(input logic [5:0] op, input regAddrT rs,
		input regAddrT rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic regAddrT randReg(input int lo);
		return regAddrT'($urandom_range(31, lo));
	endfunction

	// LUI then a dependent ORI
	task automatic loadReg(input regAddrT r, input wordT value);
		tick(1'b1, iType(opLui, 5'd0, r, value[31:16]));
		tick(1'b1, iType(opOri, r, r, value[15:0]));
	endtask

	task automatic drainPipe();
		tick(1'b0, '0);
		tick(1'b0, '0);
	endtask

	// Debug port sweep, one register per cycle
	task automatic readAllRegs();
		drainPipe();
		dbgAddr = '0;
		for (int i = 0; i < numRegs; i++)
		begin
			tick(1'b0, '0);
			checkEq("dbgData", modelRegs[i], dbgData);
			dbgAddr = regAddrT'(i + 1);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		drainPipe();
		testCount++;
		$display("Test %s finished with %0d errors", testName, testErrors);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic testLoadsLogic();
		aluOpT ops [6];
		int unsigned pick;
		ops = '{functAnd, functOr, functXor, functNor, functAddu, functSubu};
		startTest("loadsLogic");
		for (int r = 1; r < numRegs; r++)
			loadReg(regAddrT'(r), $urandom);
		for (int n = 0; n < logicOps; n++)
		begin
			pick = $urandom_range(6, 0);
			// Slot 6 stands for ADDIU
			if (pick == 6)
				tick(1'b1, iType(opAddiu, randReg(1), randReg(1), 16'($urandom)));
			else
				tick(1'b1, rType(ops[pick], randReg(1), randReg(1), randReg(1), 5'd0));
		end
		readAllRegs();
		finishTest();
	endtask

	task automatic testShifts();
		aluOpT ops [6];
		wordT value;
		ops = '{functSll, functSrl, functSra, functSllv, functSrlv, functSrav};
		startTest("shifts");
		// Sources r1..r8, odd ones negative
		for (int r = 1; r <= 8; r++)
		begin
			value = $urandom;
			value[31] = r[0];
			loadReg(regAddrT'(r), value);
		end
		for (int n = 0; n < shiftOps; n++)
			tick(1'b1, rType(ops[$urandom_range(5, 0)], regAddrT'($urandom_range(8, 1)),
				regAddrT'($urandom_range(8, 1)), randReg(9), 5'($urandom)));
		finishTest();
	endtask

	task automatic testCompares();
		wordT neg;
		wordT pos;
		startTest("compares");
		for (int n = 0; n < compareOps; n++)
		begin
			neg = $urandom | 32'h8000_0000;
			pos = $urandom & 32'h7FFF_FFFF;
			// Both orders of the sign mismatch
			loadReg(5'd1, n[0] ? neg : pos);
			loadReg(5'd2, n[0] ? pos : neg);
			tick(1'b1, rType(functSlt, 5'd1, 5'd2, 5'd3, 5'd0));
			tick(1'b1, rType(functSltu, 5'd1, 5'd2, 5'd4, 5'd0));
		end
		finishTest();
	endtask

	task automatic testOverflow();
		wordT edges [5];
		aluOpT ops [4];
		wordT opA;
		wordT opB;
		edges = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0};
		ops = '{functAdd, functSub, functAddu, functSubu};
		startTest("overflow");
		for (int n = 0; n < ovfOps; n++)
		begin
			opA = n[0] ? edges[$urandom_range(4, 0)] : $urandom;
			opB = n[1] ? edges[$urandom_range(4, 0)] : $urandom;
			loadReg(5'd1, opA);
			loadReg(5'd2, opB);
			tick(1'b1, rType(ops[$urandom_range(3, 0)], 5'd1, 5'd2, randReg(3), 5'd0));
		end
		// Trapped destinations keep old values
		readAllRegs();
		finishTest();
	endtask

	task automatic testChains();
		aluOpT ops [5];
		regAddrT older;
		regAddrT newer;
		regAddrT dest;
		ops = '{functAddu, functSubu, functXor, functOr, functSllv};
		startTest("forwarding");
		older = 5'd1;
		newer = 5'd2;
		for (int n = 0; n < chainOps; n++)
		begin
			dest = randReg(1);
			if (n % 4 == 3)
				tick(1'b1, iType(opAddiu, newer, dest, 16'($urandom)));
			else
				tick(1'b1, rType(ops[$urandom_range(4, 0)], newer,
					$urandom_range(1, 0) ? older : newer, dest, 5'd0));
			older = newer;
			newer = dest;
		end
		finishTest();
	endtask

	task automatic testZeroIllegal();
		logic [5:0] code;
		wordT word;
		startTest("zeroIllegal");
		for (int n = 0; n < zeroOps; n++)
		begin
			if (n[0])
				tick(1'b1, iType(opAddiu, randReg(1), 5'd0, 16'($urandom)));
			else
				tick(1'b1, rType(functOr, randReg(1), randReg(1), 5'd0, 5'd0));
		end
		for (int n = 0; n < illegalOps; n++)
		begin
			word = $urandom;
			if (n[0])
			begin
				// Unknown funct under R-type
				do
					code = 6'($urandom);
				while (functKnown(code));
				word[31:26] = opRType;
				word[5:0] = code;
			end
			else
			begin
				do
					code = 6'($urandom);
				while (code == opRType || code == opAddiu || code == opOri || code == opLui);
				word[31:26] = code;
			end
			tick(1'b1, word);
		end
		readAllRegs();
		finishTest();
	endtask

	initial
	begin
		instr = '0;
		instrValid = 1'b0;
		dbgAddr = '0;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		testCount = 0;
		for (int r = 0; r < numRegs; r++)
			modelRegs[r] = '0;
		for (int i = 0; i < 2; i++)
		begin
			predWb[i] = 1'b0;
			predAddr[i] = '0;
			predData[i] = '0;
			predOvf[i] = 1'b0;
			predIll[i] = 1'b0;
		end
		void'($urandom(randSeed));
		@(negedge rstN);
		@(posedge rstN);
		testLoadsLogic();
		testShifts();
		testCompares();
		testOverflow();
		testChains();
		testZeroIllegal();
		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* common/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Basic types
	////////////////////////////////////////////////////////////

	// One data word
	typedef logic [31:0] wordT;
	// Register index
	typedef logic [4:0] regAddrT;
	// ALU operation code, same space as the funct field
	typedef logic [5:0] aluOpT;

	// Architectural register count
	localparam int numRegs = 32;

	////////////////////////////////////////////////////////////
	// Funct field values for R-type
	////////////////////////////////////////////////////////////

	// Arithmetic
	localparam aluOpT functAdd = 6'b100000;
	localparam aluOpT functAddu = 6'b100001;
	localparam aluOpT functSub = 6'b100010;
	localparam aluOpT functSubu = 6'b100011;
	// Logic and compares
	localparam aluOpT functAnd = 6'b100100;
	localparam aluOpT functOr = 6'b100101;
	localparam aluOpT functXor = 6'b100110;
	localparam aluOpT functNor = 6'b100111;
	localparam aluOpT functSlt = 6'b101010;
	localparam aluOpT functSltu = 6'b101011;
	// Shifts by shamt
	localparam aluOpT functSll = 6'b000000;
	localparam aluOpT functSrl = 6'b000010;
	localparam aluOpT functSra = 6'b000011;
	// Shifts by rs
	localparam aluOpT functSllv = 6'b000100;
	localparam aluOpT functSrlv = 6'b000110;
	localparam aluOpT functSrav = 6'b000111;

	// LUI only, no funct uses this value
	localparam aluOpT aluLui = 6'b111111;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opLui = 6'b001111;

endpackage

/* hdl/execCore.sv */
`timescale 1ns/10ps

module execCore import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	// Instruction input
	input wordT instr,
	input logic instrValid,
	// Debug register read
	input regAddrT dbgAddr,
	output wordT dbgData,
	// Writeback status
	output logic wbValid,
	output regAddrT wbAddr,
	output wordT wbData,
	output logic overflow,
	output logic illegal
);

	////////////////////////////////////////////////////////////
	// Decoder to pipeline
	////////////////////////////////////////////////////////////

	aluOpT aluOp;
	regAddrT rsAddr;
	regAddrT rtAddr;
	regAddrT destAddr;
	logic useImm;
	logic writes;
	logic isIllegal;
	wordT immValue;
	logic [4:0] shamt;

	// Register file reads and write enable
	wordT rsData;
	wordT rtData;
	logic wrEn;

	instrDecode u_instrDecode (
		.instr(instr),
		.aluOp(aluOp),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.destAddr(destAddr),
		.useImm(useImm),
		.immValue(immValue),
		.shamt(shamt),
		.writes(writes),
		.isIllegal(isIllegal)
	);

	// Write port doubles as the wb outputs
	executePipe u_executePipe (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.aluOp(aluOp),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.destAddr(destAddr),
		.useImm(useImm),
		.writes(writes),
		.isIllegal(isIllegal),
		.immValue(immValue),
		.shamt(shamt),
		.rsData(rsData),
		.rtData(rtData),
		.wrEn(wrEn),
		.wrAddr(wbAddr),
		.wrData(wbData),
		.wbValid(wbValid),
		.overflow(overflow),
		.illegal(illegal)
	);

	regFile u_regFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rsAddr),
		.rdAddrB(rtAddr),
		.rdDataA(rsData),
		.rdDataB(rtData),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData),
		.wrEn(wrEn),
		.wrAddr(wbAddr),
		.wrData(wbData)
	);

endmodule

/* hdl/executePipe.sv */
`timescale 1ns/10ps

module executePipe import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	// Decoded fields of the incoming instruction
	input aluOpT aluOp,
	input regAddrT rsAddr,
	input regAddrT rtAddr,
	input regAddrT destAddr,
	input logic useImm,
	input logic writes,
	input logic isIllegal,
	input wordT immValue,
	input logic [4:0] shamt,
	// Register file read data
	input wordT rsData,
	input wordT rtData,
	// Register file write port
	output logic wrEn,
	output regAddrT wrAddr,
	output wordT wrData,
	// Writeback status
	output logic wbValid,
	output logic overflow,
	output logic illegal
);

	////////////////////////////////////////////////////////////
	// Stage 1 state
	////////////////////////////////////////////////////////////

	logic s1Valid;
	aluOpT s1AluOp;
	regAddrT s1Dest;
	logic s1Writes;
	logic s1Illegal;
	logic [4:0] s1Shamt;
	wordT s1OpA;
	// Already muxed with the immediate
	wordT s1OpB;

	wordT aluResult;
	logic aluOvf;
	// Stage 1 will commit its result
	logic s1Commit;

	wordT fwdA;
	wordT fwdB;

	aluCore u_aluCore (
		.aluOp(s1AluOp),
		.a(s1OpA),
		.b(s1OpB),
		.shamt(s1Shamt),
		.result(aluResult),
		.ovf(aluOvf)
	);

	assign s1Commit = s1Valid && s1Writes && !aluOvf && (s1Dest != '0);

	////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Youngest producer first
		if (s1Commit && (s1Dest == rsAddr))
			fwdA = aluResult;
		else if (wbValid && (wrAddr == rsAddr))
			fwdA = wrData;
		else
			fwdA = rsData;

		if (s1Commit && (s1Dest == rtAddr))
			fwdB = aluResult;
		else if (wbValid && (wrAddr == rtAddr))
			fwdB = wrData;
		else
			fwdB = rtData;
	end

	////////////////////////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////////////////////////

	// Control bits
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			s1Valid <= 1'b0;
			wbValid <= 1'b0;
			overflow <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			s1Valid <= instrValid;
			wbValid <= s1Commit;
			// Illegal codes report only the illegal flag
			overflow <= s1Valid && !s1Illegal && aluOvf;
			illegal <= s1Valid && s1Illegal;
		end
	end

	// Stage 1 payload, loaded on each accepted instruction
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			s1AluOp <= aluOp;
			s1Dest <= destAddr;
			s1Writes <= writes;
			s1Illegal <= isIllegal;
			s1Shamt <= shamt;
			s1OpA <= fwdA;
			s1OpB <= useImm ? immValue : fwdB;
		end
	end

	// Stage 2 payload
	always_ff @(posedge clk)
	begin
		if (s1Valid)
		begin
			wrAddr <= s1Dest;
			wrData <= aluResult;
		end
	end

	// Write port follows the committed writeback
	assign wrEn = wbValid;

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode import mipsPkg::*; (
	input wordT instr,
	output aluOpT aluOp,
	output regAddrT rsAddr,
	output regAddrT rtAddr,
	output regAddrT destAddr,
	output logic useImm,
	output wordT immValue,
	output logic [4:0] shamt,
	output logic writes,
	output logic isIllegal
);

	logic [5:0] opcode;
	aluOpT funct;
	logic functOk;

	// Instruction fields
	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];
	assign shamt = instr[10:6];

	// Supported R-type functs
	always_comb
	begin
		case (funct)
			functAdd, functAddu, functSub, functSubu,
			functAnd, functOr, functXor, functNor,
			functSlt, functSltu,
			functSll, functSrl, functSra,
			functSllv, functSrlv, functSrav:
				functOk = 1'b1;
			default:
				functOk = 1'b0;
		endcase
	end

	always_comb
	begin
		// R-type defaults, funct passes straight through
		aluOp = funct;
		destAddr = instr[15:11];
		useImm = 1'b0;
		immValue = '0;
		writes = 1'b0;
		isIllegal = 1'b0;
		case (opcode)
			opRType:
			begin
				writes = functOk;
				isIllegal = !functOk;
			end
			opAddiu:
			begin
				aluOp = functAddu;
				destAddr = rtAddr;
				useImm = 1'b1;
				// Sign extended
				immValue = {{16{instr[15]}}, instr[15:0]};
				writes = 1'b1;
			end
			opOri, opLui:
			begin
				aluOp = (opcode == opLui) ? aluLui : functOr;
				destAddr = rtAddr;
				useImm = 1'b1;
				// Zero extended
				immValue = {16'b0, instr[15:0]};
				writes = 1'b1;
			end
			default:
				isIllegal = 1'b1;
		endcase
	end

endmodule

/* regFile/regFile.sv */
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	// Operand read ports
	input regAddrT rdAddrA,
	input regAddrT rdAddrB,
	output wordT rdDataA,
	output wordT rdDataB,
	// Debug read port
	input regAddrT dbgAddr,
	output wordT dbgData,
	// Write port
	input logic wrEn,
	input regAddrT wrAddr,
	input wordT wrData
);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	wordT regs [numRegs];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			// All registers start at zero
			for (int i = 0; i < numRegs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn && (wrAddr != '0))
		begin
			// Register 0 ignores writes
			regs[wrAddr] <= wrData;
		end
	end

	////////////////////////////////////////////////////////////
	// Combinational reads
	////////////////////////////////////////////////////////////

	// Register 0 is hardwired to zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
	assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the execCore regression with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert --timescale 1ns/10ps \
	--top-module tbExecCore -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbExecCore > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Regression passed$" "$logFile"; then
	exit 0
fi
echo "Pass line not found in $logFile"
exit 1

/* tb.f */
common/mipsPkg.sv
alu/aluCore.sv
regFile/regFile.sv
hdl/instrDecode.sv
hdl/executePipe.sv
hdl/execCore.sv
bench/clkGen.sv
bench/execCoreProps.sv
bench/tbExecCore.sv
